//--- usb_rx_phy.f
hw/usb_line_pkg.sv
hw/usb_rx_pkg.sv
hw/usb_line_sampler.sv
hw/usb_rx_dpll.sv
hw/usb_sync_detect.sv
hw/usb_rx_decoder.sv
hw/usb_bus_reset_detect.sv
hw/usb_rx_phy.sv
tests/usb_rx_phy_assert.sv
tests/usb_rx_phy_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f usb_rx_phy.f --top-module usb_rx_phy_tb \
		-o Vusb_rx_phy_tb
	./obj_dir/Vusb_rx_phy_tb

clean:
	rm -rf obj_dir

//--- tests/usb_rx_phy_tb.sv
`timescale 1ns/1ps

module usb_rx_phy_tb import usb_line_pkg::*, usb_rx_pkg::*;;

  localparam int NUM_RANDOM   = 12;
  localparam int NUM_STUFF    = 4;
  localparam int PKT_BITS_MAX = 64;
  // Every packet, error case and the long SE0 stay under PKT_BITS_MAX bit times.
  localparam int TEST_BITS    = (NUM_RANDOM + NUM_STUFF + 8) * PKT_BITS_MAX + 40;

  logic                 clk;
  logic                 rst_n;
  logic                 rxd, rxdp, rxdn, rx_en;
  logic [BYTE_BITS-1:0] data;
  logic                 rx_valid, rx_active, rx_error, usb_rst;
  line_state_e          line_state;

  logic [31:0]          lfsr;
  logic                 lvl;
  logic [7:0]           pkt[$];
  logic [7:0]           exp_q[$];
  string                test_name;
  int                   err_cnt, active_rises, rst_rises;
  logic                 active_d, rst_d;
  logic                 check_data;
  logic [1:0]           line_d1, line_d2;

  usb_rx_phy #(
    .RST_CNT_W (5)
  ) u_dut (
    .i_rx_phy_clk (clk),
    .i_tx_phy_rst (rst_n),
    .i_rxd        (rxd),
    .i_rxdp       (rxdp),
    .i_rxdn       (rxdn),
    .i_rx_en      (rx_en),
    .o_data       (data),
    .o_rx_valid   (rx_valid),
    .o_rx_active  (rx_active),
    .o_rx_error   (rx_error),
    .o_line_state (line_state),
    .o_usb_rst    (usb_rst)
  );

  always #5 clk = ~clk;

  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
      v = (v << 1) | int'(lfsr_bit());
    return v;
  endfunction

  task automatic check_eq(input string name, input int exp, input int act);
    assert (exp == act)
    else
    begin
      $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
    else
    begin
      $display("%s: %s", test_name, what);
      $display("Simulation FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // Holds one line symbol for a full bit time of four clocks.
  task automatic drive_bit(input logic dp, input logic dn);
    @(posedge clk);
    #1;
    rxdp = dp;
    rxd  = dp;
    rxdn = dn;
    repeat (3) @(posedge clk);
  endtask

  // NRZI: a zero toggles the line, a one keeps it.
  task automatic send_nrzi(input logic b);
    if (!b)
      lvl = ~lvl;
    drive_bit(lvl, ~lvl);
  endtask

  task automatic send_idle(input int n);
    lvl = 1'b1;
    repeat (n) drive_bit(1'b1, 1'b0);
  endtask

  task automatic send_eop();
    repeat (2) drive_bit(1'b0, 1'b0);
    send_idle(1);
  endtask

  // Sends pkt with sync; nbits limits the data bits, stuff_en controls stuffing.
  task automatic send_packet(input logic stuff_en, input int nbits, input logic expect_rx);
    int run;
    int sent;
    logic b;
    run  = 1;
    sent = 0;
    for (int i = 0; i < 7; i++)
      send_nrzi(1'b0);
    send_nrzi(1'b1);
    foreach (pkt[i])
    begin
      if (expect_rx)
        exp_q.push_back(pkt[i]);
      for (int k = 0; k < 8; k++)
      begin
        if (sent < nbits)
        begin
          b = pkt[i][k];
          send_nrzi(b);
          sent++;
          run = b ? run + 1 : 0;
          if (stuff_en && run == STUFF_LIMIT)
          begin
            send_nrzi(1'b0);
            run = 0;
          end
        end
      end
    end
    send_eop();
    send_idle(8);
  endtask

  task automatic apply_reset();
    #1;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    send_idle(8);
  endtask

  task automatic check_clean_packet(input int err_before);
    int n;
    n = 0;
    while (rx_active && n < 40)
    begin
      @(posedge clk);
      n++;
    end
    check_true(!rx_active, "rx_active still high after end of packet");
    check_eq({test_name, " bytes left"}, 0, exp_q.size());
    check_eq({test_name, " errors"}, err_before, err_cnt);
  endtask

  // Scoreboard and event counters sample the registered outputs on the clock.
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (rx_valid && check_data)
      begin
        check_true(exp_q.size() > 0, "byte received that was never sent");
        check_eq({test_name, " data"}, exp_q.pop_front(), data);
      end
      check_eq({test_name, " line_state"}, int'(line_d2), int'(line_state));
      if (rx_error)
        err_cnt++;
      if (rx_active && !active_d)
        active_rises++;
      if (usb_rst && !rst_d)
        rst_rises++;
    end
    active_d <= rx_active;
    rst_d    <= usb_rst;
    // The line state trails the line inputs by two clocks.
    line_d1  <= {rxdn, rxdp};
    line_d2  <= line_d1;
  end

  initial
  begin
    #(2 * TEST_BITS * 4 * 10);
    $display("Watchdog expired before the tests completed");
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

  initial
  begin
    int e0, a0, len;
    clk          = 1'b0;
    rst_n        = 1'b0;
    rxd          = 1'b1;
    rxdp         = 1'b1;
    rxdn         = 1'b0;
    rx_en        = 1'b1;
    lvl          = 1'b1;
    lfsr         = 32'h3527;
    err_cnt      = 0;
    active_rises = 0;
    rst_rises    = 0;
    active_d     = 1'b0;
    rst_d        = 1'b0;
    check_data   = 1'b1;
    test_name    = "reset";
    apply_reset();

    test_name = "random";
    for (int p = 0; p < NUM_RANDOM; p++)
    begin
      e0  = err_cnt;
      len = 1 + rand_bits(2);
      pkt.delete();
      for (int i = 0; i < len; i++)
        pkt.push_back(8'(rand_bits(8)));
      send_packet(1'b1, 32, 1'b1);
      check_clean_packet(e0);
    end

    test_name = "stuffing";
    for (int p = 0; p < NUM_STUFF; p++)
    begin
      e0 = err_cnt;
      pkt.delete();
      pkt.push_back(8'hff);
      pkt.push_back(8'(rand_bits(8)) | 8'hfc);
      pkt.push_back(8'hff);
      pkt.push_back(8'h7f);
      send_packet(1'b1, 32, 1'b1);
      check_clean_packet(e0);
    end

    test_name = "sync_error";
    e0 = err_cnt;
    a0 = active_rises;
    drive_bit(1'b0, 1'b1);
    drive_bit(1'b0, 1'b1);
    send_idle(10);
    check_true(err_cnt > e0, "invalid sync gave no rx_error pulse");
    check_eq("sync_error active", a0, active_rises);
    apply_reset();

    // A corrupted packet still delivers whatever bytes it assembled.
    check_data = 1'b0;

    test_name = "stuff_error";
    e0 = err_cnt;
    pkt.delete();
    pkt.push_back(8'hfe);
    pkt.push_back(8'h00);
    send_packet(1'b0, 16, 1'b0);
    check_true(err_cnt > e0, "seven ones gave no rx_error pulse");
    apply_reset();

    test_name = "byte_error";
    e0 = err_cnt;
    pkt.delete();
    pkt.push_back(8'h00);
    send_packet(1'b1, 3, 1'b0);
    check_true(err_cnt > e0, "packet cut by SE0 gave no rx_error pulse");
    apply_reset();

    check_data = 1'b1;

    test_name = "bus_reset";
    check_eq("eop usb_rst rises", 0, rst_rises);
    repeat (40) drive_bit(1'b0, 1'b0);
    check_eq("bus_reset usb_rst", 1, int'(usb_rst));
    send_idle(2);
    check_eq("bus_reset release", 0, int'(usb_rst));
    check_eq("bus_reset rises", 1, rst_rises);
    apply_reset();

    test_name = "rx_disabled";
    a0 = active_rises;
    #1;
    rx_en = 1'b0;
    pkt.delete();
    pkt.push_back(8'h5a);
    send_packet(1'b1, 8, 1'b0);
    check_eq("rx_disabled active", a0, active_rises);
    #1;
    rx_en = 1'b1;

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- tests/usb_rx_phy_assert.sv
`timescale 1ns/1ps

module usb_rx_phy_assert import usb_line_pkg::*; (
  input logic        i_rx_phy_clk,
  input logic        i_tx_phy_rst,
  input logic        o_rx_valid,
  input logic        o_rx_active,
  input logic        o_usb_rst,
  input line_state_e o_line_state
);

  // A byte is only delivered inside a packet.
  valid_in_packet: assert property (@(posedge i_rx_phy_clk) disable iff (!i_tx_phy_rst)
    o_rx_valid |-> o_rx_active)
    else $error("rx_valid seen while rx_active is low");

  valid_single: assert property (@(posedge i_rx_phy_clk) disable iff (!i_tx_phy_rst)
    o_rx_valid |=> !o_rx_valid)
    else $error("rx_valid held for two cycles");

  // Bus reset has to drop soon after the line leaves SE0.
  rst_release: assert property (@(posedge i_rx_phy_clk) disable iff (!i_tx_phy_rst)
    (o_line_state != LS_SE0) [*3] |-> !o_usb_rst)
    else $error("usb_rst still high with the line out of SE0");

endmodule

bind usb_rx_phy usb_rx_phy_assert u_assert (
  .i_rx_phy_clk (i_rx_phy_clk),
  .i_tx_phy_rst (i_tx_phy_rst),
  .o_rx_valid   (o_rx_valid),
  .o_rx_active  (o_rx_active),
  .o_usb_rst    (o_usb_rst),
  .o_line_state (o_line_state)
);

//--- hw/usb_rx_phy.sv
`timescale 1ns/1ps

module usb_rx_phy import usb_line_pkg::*, usb_rx_pkg::*; #(
  parameter int RST_CNT_W = 5
) (
  input  logic                 i_rx_phy_clk,
  input  logic                 i_tx_phy_rst,
  input  logic                 i_rxd,
  input  logic                 i_rxdp,
  input  logic                 i_rxdn,
  input  logic                 i_rx_en,
  output logic [BYTE_BITS-1:0] o_data,
  output logic                 o_rx_valid,
  output logic                 o_rx_active,
  output logic                 o_rx_error,
  output line_state_e          o_line_state,
  output logic                 o_usb_rst
);

  logic rxd_s, j, k, se0;
  logic fs_ce;
  logic synced, sync_err;

  usb_line_sampler u_sampler (
    .i_rx_phy_clk (i_rx_phy_clk),
    .i_rxd        (i_rxd),
    .i_rxdp       (i_rxdp),
    .i_rxdn       (i_rxdn),
    .o_rxd_s      (rxd_s),
    .o_j          (j),
    .o_k          (k),
    .o_se0        (se0),
    .o_line_state (o_line_state)
  );

  usb_rx_dpll u_dpll (
    .i_rx_phy_clk (i_rx_phy_clk),
    .i_tx_phy_rst (i_tx_phy_rst),
    .i_rxd_s      (rxd_s),
    .i_rx_en      (i_rx_en),
    .o_fs_ce      (fs_ce)
  );

  usb_sync_detect u_sync (
    .i_rx_phy_clk (i_rx_phy_clk),
    .i_tx_phy_rst (i_tx_phy_rst),
    .i_fs_ce      (fs_ce),
    .i_j          (j),
    .i_k          (k),
    .i_se0        (se0),
    .i_rx_en      (i_rx_en),
    .i_rx_active  (o_rx_active),
    .o_synced     (synced),
    .o_sync_err   (sync_err)
  );

  usb_rx_decoder u_decoder (
    .i_rx_phy_clk (i_rx_phy_clk),
    .i_tx_phy_rst (i_tx_phy_rst),
    .i_fs_ce      (fs_ce),
    .i_rxd_s      (rxd_s),
    .i_se0        (se0),
    .i_synced     (synced),
    .i_sync_err   (sync_err),
    .o_data       (o_data),
    .o_rx_valid   (o_rx_valid),
    .o_rx_active  (o_rx_active),
    .o_rx_error   (o_rx_error)
  );

  usb_bus_reset_detect #(
    .RST_CNT_W (RST_CNT_W)
  ) u_bus_reset (
    .i_rx_phy_clk (i_rx_phy_clk),
    .i_tx_phy_rst (i_tx_phy_rst),
    .i_fs_ce      (fs_ce),
    .i_line_state (o_line_state),
    .o_usb_rst    (o_usb_rst)
  );

endmodule

//--- hw/usb_bus_reset_detect.sv
`timescale 1ns/1ps

module usb_bus_reset_detect import usb_line_pkg::*; #(
  parameter int RST_CNT_W = 5
) (
  input  logic        i_rx_phy_clk,
  input  logic        i_tx_phy_rst,
  input  logic        i_fs_ce,
  input  line_state_e i_line_state,
  output logic        o_usb_rst
);

  logic [RST_CNT_W-1:0] rst_cnt;

  // Counts bit times of continuous SE0 and stops once reset is flagged.
  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
    if (!i_tx_phy_rst)
      rst_cnt <= '0;
    else if (i_line_state != LS_SE0)
      rst_cnt <= '0;
    else if (!o_usb_rst && i_fs_ce)
      rst_cnt <= rst_cnt + 1'b1;

  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
    if (!i_tx_phy_rst)
      o_usb_rst <= 1'b0;
    else
      o_usb_rst <= &rst_cnt;

endmodule

//--- hw/usb_rx_decoder.sv
`timescale 1ns/1ps

module usb_rx_decoder import usb_line_pkg::*, usb_rx_pkg::*; (
  input  logic                 i_rx_phy_clk,
  input  logic                 i_tx_phy_rst,
  input  logic                 i_fs_ce,
  input  logic                 i_rxd_s,
  input  logic                 i_se0,
  input  logic                 i_synced,
  input  logic                 i_sync_err,
  output logic [BYTE_BITS-1:0] o_data,
  output logic                 o_rx_valid,
  output logic                 o_rx_active,
  output logic                 o_rx_error
);

  localparam int ONE_CNT_W = $clog2(STUFF_LIMIT + 1);

  logic                 rx_valid_r, rx_valid1, valid_d;
  logic                 shift_en, sd_r, sd_nrzi, drop_bit;
  logic                 bit_stuff_err, byte_err, se0_r;
  logic [ONE_CNT_W-1:0] one_cnt;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [BYTE_BITS-1:0] hold_reg, hold_next;

  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
    if (!i_tx_phy_rst)
    begin
      o_rx_active <= 1'b0;
      rx_valid_r  <= 1'b0;
      shift_en    <= 1'b0;
      sd_nrzi     <= 1'b0;
      se0_r       <= 1'b0;
    end
    else
    begin
      // Active ends at the first SE0 that follows a completed byte.
      if (i_synced)
        o_rx_active <= 1'b1;
      else if (i_se0 && rx_valid_r)
        o_rx_active <= 1'b0;
      if (o_rx_valid)
        rx_valid_r <= 1'b1;
      else if (i_fs_ce)
        rx_valid_r <= 1'b0;
      if (i_fs_ce)
        shift_en <= i_synced | o_rx_active;
      // NRZI: no transition on the line is a one.
      if (!o_rx_active)
        sd_nrzi <= 1'b1;
      else if (i_fs_ce)
        sd_nrzi <= !(i_rxd_s ^ sd_r);
      se0_r <= i_se0;
    end

  always_ff @(posedge i_rx_phy_clk)
    if (i_fs_ce)
      sd_r <= i_rxd_s;

  assign drop_bit = (one_cnt == ONE_CNT_W'(STUFF_LIMIT));

  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
    if (!i_tx_phy_rst)
    begin
      one_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (!shift_en)
    begin
      one_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (i_fs_ce)
    begin
      one_cnt <= (!sd_nrzi || drop_bit) ? '0 : one_cnt + 1'b1;
      if (!drop_bit)
        bit_cnt <= bit_cnt + 1'b1;
    end

  // The first shift after sync pushes a filler bit that falls out by the valid pulse.
  assign hold_next = {sd_nrzi, hold_reg[BYTE_BITS-1:1]};
  assign valid_d   = !drop_bit & rx_valid1 & i_fs_ce;

  always_ff @(posedge i_rx_phy_clk)
  begin
    if (i_fs_ce && shift_en && !drop_bit)
      hold_reg <= hold_next;
    if (valid_d)
      o_data <= hold_next;
  end

  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
    if (!i_tx_phy_rst)
    begin
      rx_valid1     <= 1'b0;
      o_rx_valid    <= 1'b0;
      bit_stuff_err <= 1'b0;
      byte_err      <= 1'b0;
    end
    else
    begin
      if (i_fs_ce && !drop_bit && (bit_cnt == BIT_CNT_W'(BYTE_BITS - 1)))
        rx_valid1 <= 1'b1;
      else if (valid_d)
        rx_valid1 <= 1'b0;
      o_rx_valid    <= valid_d;
      bit_stuff_err <= drop_bit & sd_nrzi & i_fs_ce & !i_se0 & o_rx_active;
      byte_err      <= i_se0 & !se0_r & (bit_cnt > BIT_CNT_W'(1)) & o_rx_active;
    end

  assign o_rx_error = i_sync_err | bit_stuff_err | byte_err;

endmodule

//--- hw/usb_sync_detect.sv
`timescale 1ns/1ps

module usb_sync_detect import usb_rx_pkg::*; (
  input  logic i_rx_phy_clk,
  input  logic i_tx_phy_rst,
  input  logic i_fs_ce,
  input  logic i_j,
  input  logic i_k,
  input  logic i_se0,
  input  logic i_rx_en,
  input  logic i_rx_active,
  output logic o_synced,
  output logic o_sync_err
);

  sync_state_e state, next_state;
  logic        synced_d, sync_err_d;
  logic        se0_s;
  logic        j_en, k_en;

  assign j_en = i_j & i_rx_en;
  assign k_en = i_k & i_rx_en;

  // SE0 seen on the previous strobe also holds the search off.
  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
    if (!i_tx_phy_rst)
      se0_s <= 1'b0;
    else if (i_fs_ce)
      se0_s <= i_se0;

  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
    if (!i_tx_phy_rst)
      state <= FS_IDLE;
    else
      state <= next_state;

  always_comb
  begin
    next_state = state;
    synced_d   = 1'b0;
    sync_err_d = 1'b0;
    if (i_fs_ce && !i_rx_active && !i_se0 && !se0_s)
    begin
      next_state = FS_IDLE;
      case (state)
        FS_IDLE: if (k_en) next_state = K1;
        K1:      if (j_en) next_state = J1;
        J1:      if (k_en) next_state = K2;
        K2:      if (j_en) next_state = J2;
        J2:      if (k_en) next_state = K3;
        K3:
          if (j_en)
            next_state = J3;
          else
            synced_d = k_en;
        J3:      if (k_en) next_state = K4;
        default: synced_d = i_k;
      endcase
      // Falling back to idle mid-pattern without a completed sync is an error.
      sync_err_d = (state != FS_IDLE) && (state != K4) &&
                   (next_state == FS_IDLE) && !synced_d;
    end
  end

  assign o_synced = synced_d & i_rx_en;

  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
    if (!i_tx_phy_rst)
      o_sync_err <= 1'b0;
    else
      o_sync_err <= sync_err_d & !i_rx_active;

endmodule

//--- hw/usb_rx_dpll.sv
`timescale 1ns/1ps

module usb_rx_dpll import usb_rx_pkg::*; (
  input  logic i_rx_phy_clk,
  input  logic i_tx_phy_rst,
  input  logic i_rxd_s,
  input  logic i_rx_en,
  output logic o_fs_ce
);

  dpll_phase_e phase, next_phase;
  logic        rxd_r;
  logic        change;
  logic        fs_ce_d, fs_ce_r1, fs_ce_r2;

  always_ff @(posedge i_rx_phy_clk)
    rxd_r <= i_rxd_s;

  assign change = (rxd_r != i_rxd_s);

  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
    if (!i_tx_phy_rst)
      phase <= PH_STROBE;
    else
      phase <= next_phase;

  // An edge on the data pulls the phase back so the strobe lands mid-bit.
  always_comb
  begin
    fs_ce_d = 1'b0;
    case (phase)
      PH_EARLY:
        next_phase = (i_rx_en && change) ? PH_EARLY : PH_STROBE;
      PH_STROBE:
      begin
        fs_ce_d    = 1'b1;
        next_phase = (i_rx_en && change) ? PH_LATE : PH_MID;
      end
      PH_MID:
        next_phase = (i_rx_en && change) ? PH_EARLY : PH_LATE;
      default:
        next_phase = PH_EARLY;
    endcase
  end

  // Three stages line the strobe up with the debounced data and symbols.
  always_ff @(posedge i_rx_phy_clk or negedge i_tx_phy_rst)
    if (!i_tx_phy_rst)
    begin
      fs_ce_r1 <= 1'b0;
      fs_ce_r2 <= 1'b0;
      o_fs_ce  <= 1'b0;
    end
    else
    begin
      fs_ce_r1 <= fs_ce_d;
      fs_ce_r2 <= fs_ce_r1;
      o_fs_ce  <= fs_ce_r2;
    end

endmodule

//--- hw/usb_line_sampler.sv
`timescale 1ns/1ps

module usb_line_sampler import usb_line_pkg::*; (
  input  logic        i_rx_phy_clk,
  input  logic        i_rxd,
  input  logic        i_rxdp,
  input  logic        i_rxdn,
  output logic        o_rxd_s,
  output logic        o_j,
  output logic        o_k,
  output logic        o_se0,
  output line_state_e o_line_state
);

  logic        rxd_s0, rxd_s1;
  logic        rxdp_s0, rxdp_s1, rxdp_q, rxdp_s;
  logic        rxdn_s0, rxdn_s1, rxdn_q, rxdn_s;
  line_state_e sym;

  // Two-flop synchronisers on all three line inputs.
  always_ff @(posedge i_rx_phy_clk)
  begin
    rxd_s0  <= i_rxd;
    rxd_s1  <= rxd_s0;
    rxdp_s0 <= i_rxdp;
    rxdp_s1 <= rxdp_s0;
    rxdn_s0 <= i_rxdn;
    rxdn_s1 <= rxdn_s0;
  end

  // The data bit only moves once two samples agree.
  always_ff @(posedge i_rx_phy_clk)
    if (rxd_s0 && rxd_s1)
      o_rxd_s <= 1'b1;
    else if (!rxd_s0 && !rxd_s1)
      o_rxd_s <= 1'b0;

  // Each half is stretched by a cycle so a glitch at a crossover cannot fake SE0.
  always_ff @(posedge i_rx_phy_clk)
  begin
    rxdp_q <= rxdp_s0 & rxdp_s1;
    rxdp_s <= (rxdp_s0 & rxdp_s1) | rxdp_q;
    rxdn_q <= rxdn_s0 & rxdn_s1;
    rxdn_s <= (rxdn_s0 & rxdn_s1) | rxdn_q;
  end

  assign sym   = line_state_e'({rxdn_s, rxdp_s});
  assign o_j   = (sym == LS_J);
  assign o_k   = (sym == LS_K);
  assign o_se0 = (sym == LS_SE0);

  assign o_line_state = line_state_e'({rxdn_s1, rxdp_s1});

endmodule

//--- hw/usb_rx_pkg.sv
package usb_rx_pkg;

  // The DPLL walks these four phases once per bit time on a steady line.
  typedef enum logic [1:0] {
    PH_EARLY  = 2'd0,
    PH_STROBE = 2'd1,
    PH_MID    = 2'd2,
    PH_LATE   = 2'd3
  } dpll_phase_e;

  // One state per symbol of the KJKJKJKK sync pattern.
  typedef enum logic [2:0] {
    FS_IDLE = 3'd0,
    K1      = 3'd1,
    J1      = 3'd2,
    K2      = 3'd3,
    J2      = 3'd4,
    K3      = 3'd5,
    J3      = 3'd6,
    K4      = 3'd7
  } sync_state_e;

  localparam int BYTE_BITS = 8;
  localparam int BIT_CNT_W = 3;

endpackage

//--- hw/usb_line_pkg.sv
package usb_line_pkg;

  // Line symbols as seen on the bus, with the bits ordered {dn, dp}.
  typedef enum logic [1:0] {
    LS_SE0 = 2'b00,
    LS_J   = 2'b01,
    LS_K   = 2'b10,
    LS_SE1 = 2'b11
  } line_state_e;

  // After this many consecutive ones the transmitter inserts a zero.
  localparam int STUFF_LIMIT = 6;

endpackage
